/* src/lsu_pkg.sv */
// Shared definitions for the load/store unit controller
// Data, address, tag and mask widths
// Access size and target enums
// Packed structs for core commands, target commands and responses,
// outstanding entries and write-back

`default_nettype none

package lsu_pkg;

  localparam int XLEN        = 32;
  localparam int ADDR_W      = 32;
  localparam int ITAG_W      = 4;
  localparam int DTCM_ADDR_W = 16;
  localparam int MASK_W      = XLEN / 8;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } lsu_size_e;

  typedef enum logic {
    TGT_DTCM = 1'b0,
    TGT_BIU  = 1'b1
  } lsu_target_e;

  // Command from the address generation stage
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              read;
    logic [XLEN-1:0]   wdata;
    logic [MASK_W-1:0] wmask;
    lsu_size_e         size;
    logic              excl;
    logic              usign;
    logic [ITAG_W-1:0] itag;
  } lsu_cmd_t;

  // Command as seen by DTCM or BIU
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              read;
    logic [XLEN-1:0]   wdata;
    logic [MASK_W-1:0] wmask;
    lsu_size_e         size;
  } lsu_bus_cmd_t;

  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic            err;
  } lsu_bus_rsp_t;

  // One in-flight command, kept until its response returns
  typedef struct packed {
    lsu_target_e       target;
    logic              scond_true;
    logic              read;
    logic              excl;
    logic              usign;
    lsu_size_e         size;
    logic [ITAG_W-1:0] itag;
    logic [ADDR_W-1:0] addr;
  } lsu_outs_entry_t;

  typedef struct packed {
    logic [XLEN-1:0]   wdat;
    logic [ITAG_W-1:0] itag;
    logic              err;
    logic [ADDR_W-1:0] badaddr;
    logic              ld;
    logic              st;
  } lsu_wbck_t;

endpackage

`default_nettype wire

/* src/lsu_excl_monitor.sv */
// Reservation monitor for load-reserved / store-conditional
// Holds the reservation flag and the reserved address, and flags
// an exclusive store that may complete

`default_nettype none

module lsu_excl_monitor (
  input  wire                     i_clk,
  input  wire                     i_rst_n,
  input  wire lsu_pkg::lsu_cmd_t  i_cmd,
  input  wire                     i_cmd_accept,
  input  wire                     i_commit_trap,
  input  wire                     i_commit_mret,
  output logic                    o_scond_true
);

  logic                       excl_flg_q;
  logic [lsu_pkg::ADDR_W-1:0] excl_addr_q;
  logic                       addr_hit;
  logic                       excl_set;
  logic                       st_clr;

  assign addr_hit = (i_cmd.addr == excl_addr_q);

  // Load-reserved going out
  assign excl_set = i_cmd_accept & i_cmd.read & i_cmd.excl;

  // Any store to the reserved address drops the reservation
  assign st_clr = i_cmd_accept & ~i_cmd.read & addr_hit & excl_flg_q;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      excl_flg_q <= 1'b0;
    end else if (excl_set) begin
      excl_flg_q <= 1'b1;
    end else if (st_clr | i_commit_trap | i_commit_mret) begin
      excl_flg_q <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (excl_set) begin
      excl_addr_q <= i_cmd.addr;
    end
  end

  // Single core, so the store-conditional result is decided here
  assign o_scond_true = i_cmd.excl & ~i_cmd.read & addr_hit & excl_flg_q;

  // Trap and mret arrive as single-cycle pulses
  a_commit_pulse: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (i_commit_trap | i_commit_mret) |=> !(i_commit_trap | i_commit_mret)
  );

endmodule

`default_nettype wire

/* src/lsu_outs_fifo.sv */
// Outstanding-command FIFO
// Circular buffer of entries with read and write pointers and an
// occupancy counter; the head reads as zero while empty

`default_nettype none

module lsu_outs_fifo #(
  parameter int DEPTH = 2
) (
  input  wire                           i_clk,
  input  wire                           i_rst_n,
  input  wire                           i_push,
  input  wire lsu_pkg::lsu_outs_entry_t i_entry,
  output logic                          o_full,
  input  wire                           i_pop,
  output logic                          o_head_valid,
  output lsu_pkg::lsu_outs_entry_t      o_head
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  lsu_pkg::lsu_outs_entry_t mem [DEPTH];
  logic [PTR_W-1:0]         wr_ptr_q;
  logic [PTR_W-1:0]         rd_ptr_q;
  logic [CNT_W-1:0]         count_q;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end else begin
      return ptr + 1'b1;
    end
  endfunction

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (i_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (i_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (i_push && !i_pop) begin
        count_q <= count_q + 1'b1;
      end else if (i_pop && !i_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      mem[wr_ptr_q] <= i_entry;
    end
  end

  assign o_full       = (count_q == CNT_W'(DEPTH));
  assign o_head_valid = (count_q != '0);

  // Head fields steer responses, so an empty buffer shows no target
  assign o_head = o_head_valid ? mem[rd_ptr_q] : '0;

  // Issue gating upstream holds off pushes into a full buffer
  a_no_push_full: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) i_push |-> !o_full
  );

  a_no_pop_empty: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) i_pop |-> o_head_valid
  );

endmodule

`default_nettype wire

/* src/lsu_target_split.sv */
// Target split between DTCM and BIU
// Address decode and issue gating, command fan-out with the
// store-conditional mask, outstanding entry build, and response
// mux steered by the FIFO head

`default_nettype none

module lsu_target_split #(
  parameter logic [lsu_pkg::ADDR_W-1:0] DTCM_BASE       = 32'h8000_0000,
  parameter int                         DTCM_REGION_LSB = 16
) (
  input  wire                           i_agu_cmd_valid,
  output logic                          o_agu_cmd_ready,
  input  wire lsu_pkg::lsu_cmd_t        i_agu_cmd,
  input  wire                           i_scond_true,
  output logic                          o_cmd_accept,
  output lsu_pkg::lsu_outs_entry_t      o_push_entry,
  input  wire                           i_fifo_full,
  input  wire                           i_head_valid,
  input  wire lsu_pkg::lsu_outs_entry_t i_head,
  output logic                          o_dtcm_cmd_valid,
  input  wire                           i_dtcm_cmd_ready,
  output lsu_pkg::lsu_bus_cmd_t         o_dtcm_cmd,
  input  wire                           i_dtcm_rsp_valid,
  output logic                          o_dtcm_rsp_ready,
  input  wire lsu_pkg::lsu_bus_rsp_t    i_dtcm_rsp,
  output logic                          o_biu_cmd_valid,
  input  wire                           i_biu_cmd_ready,
  output lsu_pkg::lsu_bus_cmd_t         o_biu_cmd,
  input  wire                           i_biu_rsp_valid,
  output logic                          o_biu_rsp_ready,
  input  wire lsu_pkg::lsu_bus_rsp_t    i_biu_rsp,
  output logic                          o_rsp_valid,
  input  wire                           i_rsp_ready,
  output lsu_pkg::lsu_bus_rsp_t         o_rsp
);

  localparam int AW = lsu_pkg::ADDR_W;

  lsu_pkg::lsu_target_e       cmd_tgt;
  logic                       in_dtcm;
  logic                       cmd_diff_tgt;
  logic                       issue_ok;
  logic                       is_scond;
  logic [lsu_pkg::MASK_W-1:0] wmask_pos;
  lsu_pkg::lsu_bus_cmd_t      bus_cmd;
  logic                       head_dtcm;
  logic                       head_biu;

  ////////////////////////////////////////////////////////////////////
  // Decode and issue

  assign in_dtcm = (i_agu_cmd.addr[AW-1:DTCM_REGION_LSB] ==
                    DTCM_BASE[AW-1:DTCM_REGION_LSB]);
  assign cmd_tgt = in_dtcm ? lsu_pkg::TGT_DTCM : lsu_pkg::TGT_BIU;

  // Only one target may have commands in flight at a time
  assign cmd_diff_tgt = i_head_valid & (i_head.target != cmd_tgt);
  assign issue_ok     = ~i_fifo_full & ~cmd_diff_tgt;

  // Both readies are required so ready has no path from the address
  assign o_agu_cmd_ready  = issue_ok & i_dtcm_cmd_ready & i_biu_cmd_ready;
  assign o_dtcm_cmd_valid = i_agu_cmd_valid & issue_ok & in_dtcm & i_biu_cmd_ready;
  assign o_biu_cmd_valid  = i_agu_cmd_valid & issue_ok & ~in_dtcm & i_dtcm_cmd_ready;
  assign o_cmd_accept     = i_agu_cmd_valid & o_agu_cmd_ready;

  // A failing store-conditional must not touch memory
  assign is_scond  = i_agu_cmd.excl & ~i_agu_cmd.read;
  assign wmask_pos = (is_scond & ~i_scond_true) ? '0 : i_agu_cmd.wmask;

  always_comb begin
    bus_cmd.addr  = i_agu_cmd.addr;
    bus_cmd.read  = i_agu_cmd.read;
    bus_cmd.wdata = i_agu_cmd.wdata;
    bus_cmd.wmask = wmask_pos;
    bus_cmd.size  = i_agu_cmd.size;
  end

  always_comb begin
    o_dtcm_cmd      = bus_cmd;
    o_dtcm_cmd.addr = AW'(i_agu_cmd.addr[lsu_pkg::DTCM_ADDR_W-1:0]);
  end

  assign o_biu_cmd = bus_cmd;

  always_comb begin
    o_push_entry.target     = cmd_tgt;
    o_push_entry.scond_true = i_scond_true;
    o_push_entry.read       = i_agu_cmd.read;
    o_push_entry.excl       = i_agu_cmd.excl;
    o_push_entry.usign      = i_agu_cmd.usign;
    o_push_entry.size       = i_agu_cmd.size;
    o_push_entry.itag       = i_agu_cmd.itag;
    o_push_entry.addr       = i_agu_cmd.addr;
  end

  ////////////////////////////////////////////////////////////////////
  // Response mux

  assign head_dtcm = i_head_valid & (i_head.target == lsu_pkg::TGT_DTCM);
  assign head_biu  = i_head_valid & (i_head.target == lsu_pkg::TGT_BIU);

  always_comb begin
    o_rsp_valid = 1'b0;
    o_rsp       = '0;
    if (head_dtcm) begin
      o_rsp_valid = i_dtcm_rsp_valid;
      o_rsp       = i_dtcm_rsp;
    end else if (head_biu) begin
      o_rsp_valid = i_biu_rsp_valid;
      o_rsp       = i_biu_rsp;
    end
  end

  assign o_dtcm_rsp_ready = head_dtcm & i_rsp_ready;
  assign o_biu_rsp_ready  = head_biu & i_rsp_ready;

endmodule

`default_nettype wire

/* src/lsu_wbck_format.sv */
// Write-back formatting
// Load data alignment and sign or zero extension by size,
// store-conditional result, bus error with faulting address,
// and load/store commit flags

`default_nettype none

module lsu_wbck_format (
  input  wire                           i_rsp_valid,
  output logic                          o_rsp_ready,
  input  wire lsu_pkg::lsu_bus_rsp_t    i_rsp,
  input  wire lsu_pkg::lsu_outs_entry_t i_head,
  output logic                          o_wbck_valid,
  input  wire                           i_wbck_ready,
  output lsu_pkg::lsu_wbck_t            o_wbck
);

  localparam int XLEN = lsu_pkg::XLEN;

  logic [XLEN-1:0] rdata_algn;
  logic [XLEN-1:0] ld_data;
  logic [XLEN-1:0] sc_data;
  logic            is_scond;

  // Every response goes to write-back
  assign o_wbck_valid = i_rsp_valid;
  assign o_rsp_ready  = i_wbck_ready;

  // Bring the addressed byte lane down to bit 0
  assign rdata_algn = i_rsp.rdata >> {i_head.addr[1:0], 3'b000};

  always_comb begin
    case (i_head.size)
      lsu_pkg::SIZE_BYTE: begin
        ld_data = i_head.usign ? {{(XLEN-8){1'b0}}, rdata_algn[7:0]}
                               : {{(XLEN-8){rdata_algn[7]}}, rdata_algn[7:0]};
      end
      lsu_pkg::SIZE_HALF: begin
        ld_data = i_head.usign ? {{(XLEN-16){1'b0}}, rdata_algn[15:0]}
                               : {{(XLEN-16){rdata_algn[15]}}, rdata_algn[15:0]};
      end
      lsu_pkg::SIZE_WORD: begin
        ld_data = rdata_algn;
      end
      default: begin
        ld_data = '0;
      end
    endcase
  end

  // 0 on success, 1 on failure
  assign is_scond = i_head.excl & ~i_head.read;
  assign sc_data  = {{(XLEN-1){1'b0}}, ~i_head.scond_true};

  always_comb begin
    o_wbck.wdat    = is_scond ? sc_data : ld_data;
    o_wbck.itag    = i_head.itag;
    o_wbck.err     = i_rsp.err;
    o_wbck.badaddr = i_head.addr;
    o_wbck.ld      = i_head.read;
    o_wbck.st      = ~i_head.read;
  end

endmodule

`default_nettype wire

/* src/lsu_ctrl.sv */
// Load/store unit controller top level
// Reservation monitor, outstanding FIFO, DTCM/BIU target split
// and write-back formatting, plus the activity flag

`default_nettype none

module lsu_ctrl #(
  parameter int                         OUTS_NUM        = 2,
  parameter logic [lsu_pkg::ADDR_W-1:0] DTCM_BASE       = 32'h8000_0000,
  parameter int                         DTCM_REGION_LSB = 16
) (
  input  wire                        i_clk,
  input  wire                        i_rst_n,
  input  wire                        i_commit_trap,
  input  wire                        i_commit_mret,
  input  wire                        i_agu_cmd_valid,
  output logic                       o_agu_cmd_ready,
  input  wire lsu_pkg::lsu_cmd_t     i_agu_cmd,
  output logic                       o_dtcm_cmd_valid,
  input  wire                        i_dtcm_cmd_ready,
  output lsu_pkg::lsu_bus_cmd_t      o_dtcm_cmd,
  input  wire                        i_dtcm_rsp_valid,
  output logic                       o_dtcm_rsp_ready,
  input  wire lsu_pkg::lsu_bus_rsp_t i_dtcm_rsp,
  output logic                       o_biu_cmd_valid,
  input  wire                        i_biu_cmd_ready,
  output lsu_pkg::lsu_bus_cmd_t      o_biu_cmd,
  input  wire                        i_biu_rsp_valid,
  output logic                       o_biu_rsp_ready,
  input  wire lsu_pkg::lsu_bus_rsp_t i_biu_rsp,
  output logic                       o_wbck_valid,
  input  wire                        i_wbck_ready,
  output lsu_pkg::lsu_wbck_t         o_wbck,
  output logic                       o_active
);

  logic                     scond_true;
  logic                     cmd_accept;
  lsu_pkg::lsu_outs_entry_t push_entry;
  logic                     fifo_full;
  logic                     fifo_pop;
  logic                     head_valid;
  lsu_pkg::lsu_outs_entry_t head;
  logic                     rsp_valid;
  logic                     rsp_ready;
  lsu_pkg::lsu_bus_rsp_t    rsp;

  lsu_excl_monitor u_excl_monitor (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_cmd         (i_agu_cmd),
    .i_cmd_accept  (cmd_accept),
    .i_commit_trap (i_commit_trap),
    .i_commit_mret (i_commit_mret),
    .o_scond_true  (scond_true)
  );

  // Entry leaves the FIFO on the response handshake
  assign fifo_pop = rsp_valid & rsp_ready;

  lsu_outs_fifo #(
    .DEPTH (OUTS_NUM)
  ) u_outs_fifo (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_push       (cmd_accept),
    .i_entry      (push_entry),
    .o_full       (fifo_full),
    .i_pop        (fifo_pop),
    .o_head_valid (head_valid),
    .o_head       (head)
  );

  lsu_target_split #(
    .DTCM_BASE       (DTCM_BASE),
    .DTCM_REGION_LSB (DTCM_REGION_LSB)
  ) u_target_split (
    .i_agu_cmd_valid  (i_agu_cmd_valid),
    .o_agu_cmd_ready  (o_agu_cmd_ready),
    .i_agu_cmd        (i_agu_cmd),
    .i_scond_true     (scond_true),
    .o_cmd_accept     (cmd_accept),
    .o_push_entry     (push_entry),
    .i_fifo_full      (fifo_full),
    .i_head_valid     (head_valid),
    .i_head           (head),
    .o_dtcm_cmd_valid (o_dtcm_cmd_valid),
    .i_dtcm_cmd_ready (i_dtcm_cmd_ready),
    .o_dtcm_cmd       (o_dtcm_cmd),
    .i_dtcm_rsp_valid (i_dtcm_rsp_valid),
    .o_dtcm_rsp_ready (o_dtcm_rsp_ready),
    .i_dtcm_rsp       (i_dtcm_rsp),
    .o_biu_cmd_valid  (o_biu_cmd_valid),
    .i_biu_cmd_ready  (i_biu_cmd_ready),
    .o_biu_cmd        (o_biu_cmd),
    .i_biu_rsp_valid  (i_biu_rsp_valid),
    .o_biu_rsp_ready  (o_biu_rsp_ready),
    .i_biu_rsp        (i_biu_rsp),
    .o_rsp_valid      (rsp_valid),
    .i_rsp_ready      (rsp_ready),
    .o_rsp            (rsp)
  );

  lsu_wbck_format u_wbck_format (
    .i_rsp_valid  (rsp_valid),
    .o_rsp_ready  (rsp_ready),
    .i_rsp        (rsp),
    .i_head       (head),
    .o_wbck_valid (o_wbck_valid),
    .i_wbck_ready (i_wbck_ready),
    .o_wbck       (o_wbck)
  );

  // Busy while a command is offered or anything is in flight
  assign o_active = i_agu_cmd_valid | head_valid;

endmodule

`default_nettype wire

/* tests/tb_lsu_ctrl.sv */
// Testbench for the load/store unit controller
// Two memory responder models for DTCM and BIU, a reference model for
// the expected write-back, directed and random stimulus, and a checker
// for write-back data, ordering, target steering, activity and back-pressure

`default_nettype none

// Byte memory behind one target port, random ready and latency
module mem_responder #(
  parameter logic [7:0] ERR_IDX = 8'hF0
) (
  input  wire                        i_clk,
  input  wire                        i_cmd_valid,
  output logic                       o_cmd_ready,
  input  wire lsu_pkg::lsu_bus_cmd_t i_cmd,
  output logic                       o_rsp_valid,
  input  wire                        i_rsp_ready,
  output lsu_pkg::lsu_bus_rsp_t      o_rsp
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [7:0]            mem [256];
  lsu_pkg::lsu_bus_rsp_t rsp_q [$];
  int                    lat_q [$];
  integer                seed;

  initial begin
    seed = 32'hf7f5;
    for (int i = 0; i < 256; i++) begin
      mem[i] = 8'(i * 29) ^ 8'hA5;
    end
    o_cmd_ready = 1'b0;
    o_rsp_valid = 1'b0;
    o_rsp       = '0;
  end

  always @(posedge i_clk) begin
    lsu_pkg::lsu_bus_rsp_t r;
    logic [7:0]            base;
    if (o_rsp_valid && i_rsp_ready) begin
      void'(rsp_q.pop_front());
      void'(lat_q.pop_front());
    end
    if (i_cmd_valid && o_cmd_ready) begin
      base    = {i_cmd.addr[7:2], 2'b00};
      r.err   = (i_cmd.addr[7:0] == ERR_IDX);
      r.rdata = '0;
      if (!r.err && i_cmd.read) begin
        r.rdata = {mem[base + 8'd3], mem[base + 8'd2], mem[base + 8'd1], mem[base]};
      end else if (!r.err) begin
        for (int b = 0; b < 4; b++) begin
          if (i_cmd.wmask[b]) begin
            mem[base + 8'(b)] = i_cmd.wdata[8*b +: 8];
          end
        end
      end
      rsp_q.push_back(r);
      lat_q.push_back(1 + ($random(seed) & 3));
    end
  end

  // Latency counts falling edges until the response shows
  always @(negedge i_clk) begin
    o_cmd_ready = (($random(seed) & 3) != 0);
    o_rsp_valid = 1'b0;
    if (rsp_q.size() > 0) begin
      if (lat_q[0] > 1) begin
        lat_q[0] = lat_q[0] - 1;
      end else begin
        o_rsp_valid = 1'b1;
        o_rsp       = rsp_q[0];
      end
    end
  end

endmodule

module tb_lsu_ctrl;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int LIMIT = 200;

  logic                  i_clk;
  logic                  i_rst_n;
  logic                  i_commit_trap;
  logic                  i_commit_mret;
  logic                  i_agu_cmd_valid;
  logic                  o_agu_cmd_ready;
  lsu_pkg::lsu_cmd_t     i_agu_cmd;
  logic                  o_dtcm_cmd_valid;
  logic                  i_dtcm_cmd_ready;
  lsu_pkg::lsu_bus_cmd_t o_dtcm_cmd;
  logic                  i_dtcm_rsp_valid;
  logic                  o_dtcm_rsp_ready;
  lsu_pkg::lsu_bus_rsp_t i_dtcm_rsp;
  logic                  o_biu_cmd_valid;
  logic                  i_biu_cmd_ready;
  lsu_pkg::lsu_bus_cmd_t o_biu_cmd;
  logic                  i_biu_rsp_valid;
  logic                  o_biu_rsp_ready;
  lsu_pkg::lsu_bus_rsp_t i_biu_rsp;
  logic                  o_wbck_valid;
  logic                  i_wbck_ready;
  lsu_pkg::lsu_wbck_t    o_wbck;
  logic                  o_active;

  lsu_pkg::lsu_wbck_t    exp_q [$];
  logic                  tgt_q [$];
  lsu_pkg::lsu_bus_cmd_t exp_bus;
  logic [3:0]            itag_next;
  logic                  resv_valid;
  logic [31:0]           resv_addr;
  logic                  bp_en;
  logic                  stall_q;
  lsu_pkg::lsu_wbck_t    held_wbck;
  integer                seed;
  string                 cur_test;
  int                    test_checks;
  int                    test_errs;
  int                    total_checks;
  int                    total_errs;

  lsu_ctrl #(
    .OUTS_NUM        (2),
    .DTCM_BASE       (32'h8000_0000),
    .DTCM_REGION_LSB (16)
  ) u_lsu_ctrl (.*);

  mem_responder #(.ERR_IDX(8'hF0)) u_dtcm_mem (
    .i_clk (i_clk), .i_cmd_valid (o_dtcm_cmd_valid), .o_cmd_ready (i_dtcm_cmd_ready),
    .i_cmd (o_dtcm_cmd), .o_rsp_valid (i_dtcm_rsp_valid), .i_rsp_ready (o_dtcm_rsp_ready),
    .o_rsp (i_dtcm_rsp)
  );

  mem_responder #(.ERR_IDX(8'hE0)) u_biu_mem (
    .i_clk (i_clk), .i_cmd_valid (o_biu_cmd_valid), .o_cmd_ready (i_biu_cmd_ready),
    .i_cmd (o_biu_cmd), .o_rsp_valid (i_biu_rsp_valid), .i_rsp_ready (o_biu_rsp_ready),
    .o_rsp (i_biu_rsp)
  );

  always #20 i_clk = ~i_clk;

  ////////////////////////////////////////////////////////////////////
  // Reference model

  function automatic logic in_dtcm(input logic [31:0] addr);
    return addr[31:16] == 16'h8000;
  endfunction

  function automatic logic [31:0] peek_word(input logic dtcm, input logic [31:0] addr);
    logic [7:0] b;
    b = {addr[7:2], 2'b00};
    if (dtcm) begin
      return {u_dtcm_mem.mem[b + 8'd3], u_dtcm_mem.mem[b + 8'd2],
              u_dtcm_mem.mem[b + 8'd1], u_dtcm_mem.mem[b]};
    end
    return {u_biu_mem.mem[b + 8'd3], u_biu_mem.mem[b + 8'd2],
            u_biu_mem.mem[b + 8'd1], u_biu_mem.mem[b]};
  endfunction

  function automatic lsu_pkg::lsu_wbck_t lsu_expect(input lsu_pkg::lsu_cmd_t c,
      input logic [31:0] rword, input logic err, input logic sc_ok);
    lsu_pkg::lsu_wbck_t w;
    logic [31:0]        lane;
    lane = rword >> (8 * c.addr[1:0]);
    if (c.size == lsu_pkg::SIZE_BYTE) begin
      w.wdat = c.usign ? {24'b0, lane[7:0]} : {{24{lane[7]}}, lane[7:0]};
    end else if (c.size == lsu_pkg::SIZE_HALF) begin
      w.wdat = c.usign ? {16'b0, lane[15:0]} : {{16{lane[15]}}, lane[15:0]};
    end else begin
      w.wdat = lane;
    end
    // Store-conditional reports 0 on success
    if (c.excl && !c.read) begin
      w.wdat = sc_ok ? 32'd0 : 32'd1;
    end
    w.itag    = c.itag;
    w.err     = err;
    w.badaddr = c.addr;
    w.ld      = c.read;
    w.st      = !c.read;
    return w;
  endfunction

  function automatic lsu_pkg::lsu_cmd_t mk_cmd(input logic [31:0] addr, input logic read,
      input lsu_pkg::lsu_size_e size, input logic usign, input logic excl,
      input logic [31:0] data);
    lsu_pkg::lsu_cmd_t c;
    logic [3:0]        m;
    m = (size == lsu_pkg::SIZE_BYTE) ? 4'h1 : (size == lsu_pkg::SIZE_HALF) ? 4'h3 : 4'hF;
    c.addr  = addr;
    c.read  = read;
    c.wdata = data << (8 * addr[1:0]);
    c.wmask = read ? 4'h0 : 4'(m << addr[1:0]);
    c.size  = size;
    c.excl  = excl;
    c.usign = usign;
    c.itag  = '0;
    return c;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Reporting

  task automatic value_fail(input string what, input logic [71:0] exp,
      input logic [71:0] act);
    $display("[FAIL] %s %s: expected %h actual %h", cur_test, what, exp, act);
    test_errs++;
    total_errs++;
  endtask

  task automatic plain_fail(input string msg);
    $display("ERROR in %s: %s", cur_test, msg);
    test_errs++;
    total_errs++;
  endtask

  task automatic abort_run(input string msg);
    $display("ERROR in %s: timed out while %s", cur_test, msg);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic check_value(input string what, input logic [31:0] exp,
      input logic [31:0] act);
    test_checks++;
    total_checks++;
    if (exp !== act) begin
      value_fail(what, 72'(exp), 72'(act));
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Checker

  always @(posedge i_clk) begin
    lsu_pkg::lsu_wbck_t    exp;
    lsu_pkg::lsu_bus_cmd_t bus;
    logic                  dtcm;
    if (i_rst_n) begin
      if (tgt_q.size() > 0 && o_dtcm_cmd_valid && !tgt_q[0]) begin
        plain_fail("DTCM command valid while a BIU entry is outstanding");
      end
      if (tgt_q.size() > 0 && o_biu_cmd_valid && tgt_q[0]) begin
        plain_fail("BIU command valid while a DTCM entry is outstanding");
      end
      if (o_active !== (i_agu_cmd_valid || tgt_q.size() > 0)) begin
        plain_fail("activity flag does not match offered and outstanding commands");
      end
      if (i_agu_cmd_valid && o_agu_cmd_ready) begin
        dtcm = in_dtcm(i_agu_cmd.addr);
        if (o_dtcm_cmd_valid !== dtcm || o_biu_cmd_valid !== !dtcm) begin
          plain_fail("command valid raised on the wrong target");
        end
        bus = dtcm ? o_dtcm_cmd : o_biu_cmd;
        if (bus !== exp_bus) begin
          value_fail("bus command", 72'(exp_bus), 72'(bus));
        end
      end
      if (stall_q && (!o_wbck_valid || o_wbck !== held_wbck)) begin
        plain_fail("write-back changed while stalled");
      end
      stall_q   = o_wbck_valid && !i_wbck_ready;
      held_wbck = o_wbck;
      if (o_wbck_valid && i_wbck_ready) begin
        if (exp_q.size() == 0) begin
          plain_fail("write-back with no command outstanding");
        end else begin
          exp = exp_q.pop_front();
          void'(tgt_q.pop_front());
          test_checks++;
          total_checks++;
          if (o_wbck !== exp) begin
            value_fail("write-back", 72'(exp), 72'(o_wbck));
          end
        end
      end
    end
  end

  always @(negedge i_clk) begin
    if (bp_en) begin
      i_wbck_ready = (($random(seed) & 1) != 0);
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Stimulus

  // Called at a falling edge, returns at the falling edge after accept
  task automatic issue(input lsu_pkg::lsu_cmd_t c);
    logic        dtcm;
    logic        is_err;
    logic        sc_ok;
    logic [31:0] word;
    int          waited;
    c.itag    = itag_next;
    itag_next = itag_next + 4'd1;
    dtcm      = in_dtcm(c.addr);
    is_err    = (c.addr[7:0] == (dtcm ? 8'hF0 : 8'hE0));
    sc_ok     = c.excl && !c.read && resv_valid && (resv_addr == c.addr);
    word      = (c.read && !is_err) ? peek_word(dtcm, c.addr) : 32'd0;
    // DTCM sees only the low address bits
    exp_bus.addr  = dtcm ? {16'h0000, c.addr[15:0]} : c.addr;
    exp_bus.read  = c.read;
    exp_bus.wdata = c.wdata;
    exp_bus.wmask = (c.excl && !c.read && !sc_ok) ? 4'h0 : c.wmask;
    exp_bus.size  = c.size;
    i_agu_cmd       = c;
    i_agu_cmd_valid = 1'b1;
    waited          = 0;
    do begin
      @(posedge i_clk);
      waited++;
      if (waited > LIMIT) begin
        abort_run("waiting for command accept");
      end
    end while (!o_agu_cmd_ready);
    exp_q.push_back(lsu_expect(c, word, is_err, sc_ok));
    tgt_q.push_back(dtcm);
    if (c.read && c.excl) begin
      resv_valid = 1'b1;
      resv_addr  = c.addr;
    end else if (!c.read && resv_valid && c.addr == resv_addr) begin
      resv_valid = 1'b0;
    end
    @(negedge i_clk);
    i_agu_cmd_valid = 1'b0;
  endtask

  task automatic commit_pulse(input logic trap);
    i_commit_trap = trap;
    i_commit_mret = !trap;
    @(negedge i_clk);
    i_commit_trap = 1'b0;
    i_commit_mret = 1'b0;
    resv_valid    = 1'b0;
  endtask

  task automatic drain_wbck();
    int waited;
    waited = 0;
    while (exp_q.size() > 0) begin
      @(negedge i_clk);
      waited++;
      if (waited > LIMIT) begin
        abort_run("draining write-backs");
      end
    end
  endtask

  task automatic finish_test();
    drain_wbck();
    $display("%s: %0d checks, %0d errors", cur_test, test_checks, test_errs);
    test_checks = 0;
    test_errs   = 0;
  endtask

  task automatic random_loads(input int n);
    logic [31:0] a;
    for (int i = 0; i < n; i++) begin
      a = (($random(seed) & 1) != 0) ? 32'h8000_0000 : 32'h0000_1000;
      a = a + 32'($random(seed) & 32'h7C);
      issue(mk_cmd(a, 1'b1, lsu_pkg::SIZE_WORD, 1'b0, 1'b0, 32'd0));
    end
  endtask

  initial begin
    logic [31:0] base;
    logic [31:0] word;
    logic [31:0] keep;
    seed = 32'hf7f5;
    i_clk = 1'b0;
    i_rst_n = 1'b0;
    i_commit_trap = 1'b0;
    i_commit_mret = 1'b0;
    i_agu_cmd_valid = 1'b0;
    i_agu_cmd = '0;
    i_wbck_ready = 1'b1;
    exp_bus = '0;
    itag_next = '0;
    resv_valid = 1'b0;
    resv_addr = '0;
    bp_en = 1'b0;
    stall_q = 1'b0;
    held_wbck = '0;
    test_checks = 0;
    test_errs = 0;
    total_checks = 0;
    total_errs = 0;
    cur_test = "reset";
    repeat (2) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;

    cur_test = "loads";
    for (int r = 0; r < 2; r++) begin
      base = r ? 32'h0000_1040 : 32'h8000_0040;
      for (int s = 0; s < 3; s++) begin
        for (int off = 0; off < 4; off += (1 << s)) begin
          for (int u = 0; u < 2; u++) begin
            issue(mk_cmd(base + 32'(off) + 32'(4 * s), 1'b1, lsu_pkg::lsu_size_e'(s),
                         u[0], 1'b0, 32'd0));
          end
        end
      end
    end
    finish_test();

    cur_test = "stores";
    for (int r = 0; r < 2; r++) begin
      base = r ? 32'h0000_1080 : 32'h8000_0080;
      issue(mk_cmd(base + 32'h1, 1'b0, lsu_pkg::SIZE_BYTE, 1'b0, 1'b0, 32'hC3));
      issue(mk_cmd(base + 32'h6, 1'b0, lsu_pkg::SIZE_HALF, 1'b0, 1'b0, 32'h9E17));
      issue(mk_cmd(base + 32'h8, 1'b0, lsu_pkg::SIZE_WORD, 1'b0, 1'b0, 32'h1234_5678));
      issue(mk_cmd(base + 32'h1, 1'b1, lsu_pkg::SIZE_BYTE, 1'b1, 1'b0, 32'd0));
      issue(mk_cmd(base + 32'h6, 1'b1, lsu_pkg::SIZE_HALF, 1'b1, 1'b0, 32'd0));
      issue(mk_cmd(base + 32'h8, 1'b1, lsu_pkg::SIZE_WORD, 1'b0, 1'b0, 32'd0));
      drain_wbck();
      word = peek_word(!r, base);
      check_value("stored byte", 32'hC3, 32'(word[15:8]));
      word = peek_word(!r, base + 32'h4);
      check_value("stored half", 32'h9E17, 32'(word[31:16]));
      check_value("stored word", 32'h1234_5678, peek_word(!r, base + 32'h8));
    end
    finish_test();

    cur_test = "bus errors";
    issue(mk_cmd(32'h8000_00F0, 1'b1, lsu_pkg::SIZE_WORD, 1'b0, 1'b0, 32'd0));
    issue(mk_cmd(32'h0000_10E0, 1'b1, lsu_pkg::SIZE_WORD, 1'b0, 1'b0, 32'd0));
    issue(mk_cmd(32'h0000_10E0, 1'b0, lsu_pkg::SIZE_WORD, 1'b0, 1'b0, 32'h55));
    finish_test();

    cur_test = "ordering";
    random_loads(24);
    finish_test();

    cur_test = "lr/sc";
    base = 32'h8000_00A0;
    issue(mk_cmd(base, 1'b1, lsu_pkg::SIZE_WORD, 1'b0, 1'b1, 32'd0));
    issue(mk_cmd(base, 1'b0, lsu_pkg::SIZE_WORD, 1'b0, 1'b1, 32'hCAFE_0001));
    drain_wbck();
    check_value("sc success data", 32'hCAFE_0001, peek_word(1'b1, base));
    issue(mk_cmd(base, 1'b1, lsu_pkg::SIZE_WORD, 1'b0, 1'b1, 32'd0));
    drain_wbck();
    commit_pulse(1'b1);
    issue(mk_cmd(base, 1'b0, lsu_pkg::SIZE_WORD, 1'b0, 1'b1, 32'hDEAD_0002));
    drain_wbck();
    check_value("sc after trap", 32'hCAFE_0001, peek_word(1'b1, base));
    keep = peek_word(1'b0, 32'h0000_10A4);
    issue(mk_cmd(32'h0000_10A0, 1'b1, lsu_pkg::SIZE_WORD, 1'b0, 1'b1, 32'd0));
    issue(mk_cmd(32'h0000_10A4, 1'b0, lsu_pkg::SIZE_WORD, 1'b0, 1'b1, 32'hBEEF_0003));
    drain_wbck();
    check_value("sc other address", keep, peek_word(1'b0, 32'h0000_10A4));
    // Reservation on 0x10A0 still stands until the mret
    commit_pulse(1'b0);
    keep = peek_word(1'b0, 32'h0000_10A0);
    issue(mk_cmd(32'h0000_10A0, 1'b0, lsu_pkg::SIZE_WORD, 1'b0, 1'b1, 32'hFACE_0004));
    drain_wbck();
    check_value("sc after mret", keep, peek_word(1'b0, 32'h0000_10A0));
    finish_test();

    cur_test = "back-pressure";
    bp_en = 1'b1;
    random_loads(24);
    finish_test();
    bp_en = 1'b0;
    i_wbck_ready = 1'b1;

    $display("total: %0d checks, %0d errors", total_checks, total_errs);
    if (total_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
src/lsu_pkg.sv
src/lsu_excl_monitor.sv
src/lsu_outs_fifo.sv
src/lsu_target_split.sv
src/lsu_wbck_format.sv
src/lsu_ctrl.sv
tests/tb_lsu_ctrl.sv

/* Bender.yml */
package:
  name: lsu_ctrl

sources:
  - src/lsu_pkg.sv
  - src/lsu_excl_monitor.sv
  - src/lsu_outs_fifo.sv
  - src/lsu_target_split.sv
  - src/lsu_wbck_format.sv
  - src/lsu_ctrl.sv
  - target: test
    files:
      - tests/tb_lsu_ctrl.sv
